//--- bench/router_tb.sv
/* Testbench for the two-port echo router: random packets on both ports, APB register
   accesses, and a per-port scoreboard that concurrent assertions check against. */
module router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import router_pkg::*;

    localparam int NUM_PKTS = 8;

    logic                      phys_port_clk_ifc;
    logic                      rst_n;
    word8_t                    ing0_tdata;
    word8_t                    egr0_tdata;
    logic                      ing0_tvalid, ing0_tready, ing0_tlast;
    logic                      egr0_tvalid, egr0_tready, egr0_tlast;
    word32_t                   ing1_tdata;
    word32_t                   egr1_tdata;
    logic                      ing1_tvalid, ing1_tready, ing1_tlast;
    logic                      egr1_tvalid, egr1_tready, egr1_tlast;
    logic                      psel, penable, pwrite, pready, pslverr;
    apb_addr_t                 paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;

    // Scoreboard of {tlast, tdata} for forwarded words not yet seen at egress
    logic [8:0]  q0 [$];
    logic [32:0] q1 [$];
    logic        fwd0, fwd1;
    logic        exp0_avail, exp1_avail, exp0_last, exp1_last;
    word8_t      exp0_data;
    word32_t     exp1_data;
    int          occ0, occ1;
    int          pkts [NUM_PORTS];
    int          len0 [NUM_PKTS];
    int          len1 [NUM_PKTS];
    int          drop_len;
    int          errors, cycles, limit, hold1_end;

    echo_router_top u_dut (.*);

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #10 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    always @(posedge phys_port_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: traffic did not drain within %0d cycles", limit);
            $display("Checks finished with %0d errors after %0d cycles", errors, cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Random egress back-pressure with a long stall on port 1
    always @(posedge phys_port_clk_ifc) begin
        if (rst_n) begin
            egr0_tready <= ($urandom % 4) != 0;
            egr1_tready <= (cycles < hold1_end) ? 1'b0 : (($urandom % 4) != 0);
        end
    end

    always @(posedge phys_port_clk_ifc) begin
        if (egr0_tvalid && egr0_tready && q0.size() != 0) void'(q0.pop_front());
        if (egr1_tvalid && egr1_tready && q1.size() != 0) void'(q1.pop_front());
        if (ing0_tvalid && ing0_tready && fwd0) q0.push_back({ing0_tlast, ing0_tdata});
        if (ing1_tvalid && ing1_tready && fwd1) q1.push_back({ing1_tlast, ing1_tdata});
        if (q0.size() != 0) {exp0_last, exp0_data} <= q0[0];
        if (q1.size() != 0) {exp1_last, exp1_data} <= q1[0];
        exp0_avail <= q0.size() != 0;
        exp1_avail <= q1.size() != 0;
        occ0       <= q0.size();
        occ1       <= q1.size();
    end

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] expected);
        errors++;
        $display("error t=%0t %s got %0h expected %0h", $time, name, got, expected);
    endfunction

    function automatic void flag_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_egr0_expected: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr0_tvalid && egr0_tready |-> exp0_avail)
        else flag_failure("Port 0 sent a word that was never forwarded");
    a_egr0_data: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr0_tvalid && egr0_tready && exp0_avail |-> egr0_tdata == exp0_data)
        else report_mismatch("egr0_tdata", $sampled(egr0_tdata), $sampled(exp0_data));
    a_egr0_last: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr0_tvalid && egr0_tready && exp0_avail |-> egr0_tlast == exp0_last)
        else report_mismatch("egr0_tlast", $sampled(egr0_tlast), $sampled(exp0_last));
    a_egr1_expected: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr1_tvalid && egr1_tready |-> exp1_avail)
        else flag_failure("Port 1 sent a word that was never forwarded");
    a_egr1_data: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr1_tvalid && egr1_tready && exp1_avail |-> egr1_tdata == exp1_data)
        else report_mismatch("egr1_tdata", $sampled(egr1_tdata), $sampled(exp1_data));
    a_egr1_last: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        egr1_tvalid && egr1_tready && exp1_avail |-> egr1_tlast == exp1_last)
        else report_mismatch("egr1_tlast", $sampled(egr1_tlast), $sampled(exp1_last));
    // Full FIFO must stall ingress
    a_ing1_full_stall: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        fwd1 && occ1 == FIFO_DEPTH |-> !ing1_tready)
        else flag_failure("Port 1 accepted a word while its FIFO was full");
    a_drop_accepts: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !fwd0 && ing0_tvalid |-> ing0_tready)
        else flag_failure("Port 0 stalled a dropped packet");
    a_apb_ready: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        psel && penable |-> pready)
        else flag_failure("APB access cycle ended without pready");

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks start and end on a rising edge

    task automatic send_packet(input int port, input int len, input logic fwd);
        logic [31:0] data;
        logic        rdy;
        for (int i = 0; i < len; i++) begin
            data = $urandom;
            if (port == 0) begin
                ing0_tvalid <= 1'b1;
                ing0_tdata  <= data[7:0];
                ing0_tlast  <= (i == len - 1);
                if (i == 0) fwd0 <= fwd;
            end else begin
                ing1_tvalid <= 1'b1;
                ing1_tdata  <= data;
                ing1_tlast  <= (i == len - 1);
                if (i == 0) fwd1 <= fwd;
            end
            @(posedge phys_port_clk_ifc);
            rdy = (port == 0) ? ing0_tready : ing1_tready;
            while (!rdy) begin
                @(posedge phys_port_clk_ifc);
                rdy = (port == 0) ? ing0_tready : ing1_tready;
            end
        end
        if (port == 0) ing0_tvalid <= 1'b0;
        else ing1_tvalid <= 1'b0;
        if (fwd) pkts[port]++;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
        @(posedge phys_port_clk_ifc);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge phys_port_clk_ifc);
        penable <= 1'b1;
        @(posedge phys_port_clk_ifc);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        @(posedge phys_port_clk_ifc);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge phys_port_clk_ifc);
        penable <= 1'b1;
        @(posedge phys_port_clk_ifc);
        data    = prdata;
        err     = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input apb_addr_t addr, input int expected, input string name);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        assert (!err) else flag_failure($sformatf("Read of %s raised pslverr", name));
        assert (data == expected) else report_mismatch(name, data, expected);
    endtask

    task automatic check_counts(input int p0, input int p1);
        check_reg(REG_ING_COUNT_BASE, p0, "ing_count[0]");
        check_reg(REG_EGR_COUNT_BASE, p0, "egr_count[0]");
        check_reg(REG_ING_COUNT_BASE + 8'(REG_COUNT_STRIDE), p1, "ing_count[1]");
        check_reg(REG_EGR_COUNT_BASE + 8'(REG_COUNT_STRIDE), p1, "egr_count[1]");
    endtask

    task automatic drain_traffic;
        while (occ0 != 0 || occ1 != 0) @(posedge phys_port_clk_ifc);
        repeat (4) @(posedge phys_port_clk_ifc);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] data;
        logic        err;
        int          total;
        void'($urandom(63788));
        {ing0_tvalid, ing0_tlast, ing1_tvalid, ing1_tlast} <= '0;
        {egr0_tready, egr1_tready, psel, penable, pwrite} <= '0;
        ing0_tdata <= '0;
        ing1_tdata <= '0;
        paddr      <= '0;
        pwdata     <= '0;
        {fwd0, fwd1, exp0_avail, exp1_avail} <= '0;
        cycles     <= 0;
        hold1_end  <= 0;
        pkts      = '{default: 0};
        errors    = 0;
        total     = 0;
        for (int k = 0; k < NUM_PKTS; k++) begin
            len0[k] = 1 + $urandom % 40;
            len1[k] = 1 + $urandom % 40;
            total   = total + len0[k] + len1[k];
        end
        drop_len = 20 + $urandom % 21;
        limit    = (total + drop_len + 5) * 4 + 2000;

        rst_n <= 1'b0;
        repeat (3) @(posedge phys_port_clk_ifc);
        rst_n <= 1'b1;
        @(posedge phys_port_clk_ifc);
        assert (!egr0_tvalid && !egr1_tvalid && !pslverr)
            else flag_failure("Egress tvalid or pslverr high after reset");
        check_reg(REG_PORT_ENABLE, 0, "port_enable");
        check_counts(0, 0);

        // Traffic on both ports while port 1 stalls for 60 cycles
        apb_write(REG_PORT_ENABLE, 32'h3);
        fork
            for (int k = 0; k < NUM_PKTS; k++) begin
                send_packet(0, len0[k], 1'b1);
                repeat ($urandom % 3) @(posedge phys_port_clk_ifc);
            end
            for (int k = 0; k < NUM_PKTS; k++) begin
                send_packet(1, len1[k], 1'b1);
                repeat ($urandom % 3) @(posedge phys_port_clk_ifc);
            end
            begin
                repeat (30) @(posedge phys_port_clk_ifc);
                hold1_end <= cycles + 60;
            end
        join
        drain_traffic();
        check_counts(pkts[0], pkts[1]);

        // Packet that starts on a disabled port which is enabled partway through
        apb_write(REG_PORT_ENABLE, 32'h2);
        fork
            send_packet(0, drop_len, 1'b0);
            begin
                repeat (6) @(posedge phys_port_clk_ifc);
                apb_write(REG_PORT_ENABLE, 32'h3);
            end
        join
        send_packet(0, 5, 1'b1);
        drain_traffic();
        check_counts(pkts[0], pkts[1]);

        apb_write(REG_COUNTER_CLEAR, 32'h1);
        check_counts(0, pkts[1]);
        check_reg(REG_COUNTER_CLEAR, 0, "counter_clear");

        apb_read(8'h40, data, err);
        assert (err) else flag_failure("Unmapped read did not raise pslverr");
        assert (data == 0) else report_mismatch("prdata", data, 0);

        $display("Checks finished with %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/router_pkg.sv
verilog/axis_ifc.sv
verilog/pkt_fifo.sv
verilog/echo_port.sv
verilog/router_regs.sv
verilog/echo_router_top.sv
bench/router_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the echo router testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module router_tb -f build.f -o router_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/router_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

//--- verilog/axis_ifc.sv
/* Packet stream between router blocks, one word per valid/ready transfer.
   The payload type is set per instance so one definition serves both port widths. */
interface axis_ifc #(
    parameter type data_t = router_pkg::word8_t
);

    data_t tdata;
    logic  tvalid;
    logic  tready;
    logic  tlast;

    // Producer of words
    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // Consumer of words
    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

//--- verilog/echo_port.sv
/* One physical port's echo path: per-packet enable gating, the word FIFO and
   the ingress and egress packet counters that the register block reads back. */
module echo_port #(
    parameter type data_t = router_pkg::word8_t
) (
    input  logic               phys_port_clk_ifc,
    input  logic               rst_n,
    axis_ifc.sink              ing,
    axis_ifc.source            egr,
    input  logic               enable,
    input  logic               clear,
    output router_pkg::counter_t ing_count,
    output router_pkg::counter_t egr_count
);

    axis_ifc #(.data_t(data_t)) fifo_in ();

    logic in_pkt;
    logic dropping;
    logic drop_now;
    logic ing_fire;
    logic egr_fire;

    // Enable only counts on the first word, later words follow the packet's fate
    assign drop_now = in_pkt ? dropping : !enable;

    assign fifo_in.tdata  = ing.tdata;
    assign fifo_in.tlast  = ing.tlast;
    assign fifo_in.tvalid = ing.tvalid && !drop_now;

    // Dropped words are swallowed at full rate
    assign ing.tready = drop_now ? 1'b1 : fifo_in.tready;

    assign ing_fire = ing.tvalid && ing.tready;
    assign egr_fire = egr.tvalid && egr.tready;

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            dropping <= 1'b0;
        end else if (ing_fire) begin
            in_pkt   <= !ing.tlast;
            dropping <= drop_now;
        end
    end

    pkt_fifo #(
        .data_t (data_t)
    ) u_fifo (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .wr                (fifo_in),
        .rd                (egr)
    );

    //////////////////////////////////////////////////////////////////////
    // Packet counters

    // Clear wins over a coincident increment
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            ing_count <= '0;
            egr_count <= '0;
        end else if (clear) begin
            ing_count <= '0;
            egr_count <= '0;
        end else begin
            if (ing_fire && ing.tlast && !drop_now) begin
                ing_count <= ing_count + 1'b1;
            end
            if (egr_fire && egr.tlast) begin
                egr_count <= egr_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    // A packet is forwarded or dropped as a whole
    a_drop_stable_in_pkt: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        in_pkt |=> !in_pkt || $stable(dropping))
        else $error("echo_port drop decision changed inside a packet");

endmodule

//--- verilog/echo_router_top.sv
/* Two-port echo router: each packet leaves on the port it arrived on.
   Port 0 is byte wide, port 1 is 32 bits wide, control is over APB. */
module echo_router_top (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst_n,

    input  router_pkg::word8_t                  ing0_tdata,
    input  logic                                ing0_tvalid,
    output logic                                ing0_tready,
    input  logic                                ing0_tlast,
    output router_pkg::word8_t                  egr0_tdata,
    output logic                                egr0_tvalid,
    input  logic                                egr0_tready,
    output logic                                egr0_tlast,

    input  router_pkg::word32_t                 ing1_tdata,
    input  logic                                ing1_tvalid,
    output logic                                ing1_tready,
    input  logic                                ing1_tlast,
    output router_pkg::word32_t                 egr1_tdata,
    output logic                                egr1_tvalid,
    input  logic                                egr1_tready,
    output logic                                egr1_tlast,

    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [router_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [router_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [router_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr
);

    import router_pkg::*;

    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] counter_clear;
    counter_t             ing_counts [NUM_PORTS];
    counter_t             egr_counts [NUM_PORTS];

    axis_ifc #(.data_t(word8_t))  ing0_bus ();
    axis_ifc #(.data_t(word8_t))  egr0_bus ();
    axis_ifc #(.data_t(word32_t)) ing1_bus ();
    axis_ifc #(.data_t(word32_t)) egr1_bus ();

    //////////////////////////////////////////////////////////////////////
    // Port 0, byte stream

    assign ing0_bus.tdata  = ing0_tdata;
    assign ing0_bus.tvalid = ing0_tvalid;
    assign ing0_bus.tlast  = ing0_tlast;
    assign ing0_tready     = ing0_bus.tready;

    assign egr0_tdata      = egr0_bus.tdata;
    assign egr0_tvalid     = egr0_bus.tvalid;
    assign egr0_tlast      = egr0_bus.tlast;
    assign egr0_bus.tready = egr0_tready;

    echo_port #(.data_t(word8_t)) u_port0 (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .ing               (ing0_bus),
        .egr               (egr0_bus),
        .enable            (port_enable[0]),
        .clear             (counter_clear[0]),
        .ing_count         (ing_counts[0]),
        .egr_count         (egr_counts[0])
    );

    //////////////////////////////////////////////////////////////////////
    // Port 1, word stream

    assign ing1_bus.tdata  = ing1_tdata;
    assign ing1_bus.tvalid = ing1_tvalid;
    assign ing1_bus.tlast  = ing1_tlast;
    assign ing1_tready     = ing1_bus.tready;

    assign egr1_tdata      = egr1_bus.tdata;
    assign egr1_tvalid     = egr1_bus.tvalid;
    assign egr1_tlast      = egr1_bus.tlast;
    assign egr1_bus.tready = egr1_tready;

    echo_port #(.data_t(word32_t)) u_port1 (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .ing               (ing1_bus),
        .egr               (egr1_bus),
        .enable            (port_enable[1]),
        .clear             (counter_clear[1]),
        .ing_count         (ing_counts[1]),
        .egr_count         (egr_counts[1])
    );

    router_regs u_regs (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .port_enable       (port_enable),
        .counter_clear     (counter_clear),
        .ing_counts        (ing_counts),
        .egr_counts        (egr_counts)
    );

endmodule

//--- verilog/pkt_fifo.sv
/* Word FIFO for one port's stream; data and tlast are stored side by side.
   Ingress back-pressure comes from the full flag, so no word is ever dropped. */
module pkt_fifo #(
    parameter type data_t = router_pkg::word8_t
) (
    input logic    phys_port_clk_ifc,
    input logic    rst_n,
    axis_ifc.sink  wr,
    axis_ifc.source rd
);

    import router_pkg::*;

    typedef struct packed {
        data_t data;
        logic  last;
    } entry_t;

    entry_t                    mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;

    logic wr_fire;
    logic rd_fire;

    assign wr.tready = (count != FIFO_DEPTH);
    assign rd.tvalid = (count != 0);
    assign rd.tdata  = mem[rd_ptr].data;
    assign rd.tlast  = mem[rd_ptr].last;

    assign wr_fire = wr.tvalid && wr.tready;
    assign rd_fire = rd.tvalid && rd.tready;

    // Storage
    always_ff @(posedge phys_port_clk_ifc) begin
        if (wr_fire) begin
            mem[wr_ptr] <= '{data: wr.tdata, last: wr.tlast};
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Guards

    // A write while full would push the count past the depth
    a_no_write_when_full: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        count == FIFO_DEPTH |=> count == FIFO_DEPTH || count == FIFO_DEPTH - 1)
        else $error("pkt_fifo write while full");

    // A read while empty would wrap the count below zero
    a_no_read_when_empty: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        count == 0 |=> count <= 1)
        else $error("pkt_fifo read while empty");

    // Occupancy and pointers must agree when drained
    a_empty_ptrs_match: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        count == 0 |-> wr_ptr == rd_ptr)
        else $error("pkt_fifo pointers out of step with count");

endmodule

//--- verilog/router_pkg.sv
/* Widths, register map and payload types shared by the echo router RTL.
   Imported by every module that needs a constant or a type. */
package router_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_PORTS      = 2;
    localparam int COUNTER_WIDTH  = 16;
    localparam int FIFO_DEPTH     = 32;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    //////////////////////////////////////////////////////////////////////
    // Payload and counter types

    // Port 0 carries bytes, port 1 carries whole 32-bit words
    typedef logic [7:0]               word8_t;
    typedef logic [31:0]              word32_t;

    typedef logic [COUNTER_WIDTH-1:0] counter_t;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Register map

    // Bit n enables port n
    localparam apb_addr_t REG_PORT_ENABLE    = 8'h00;

    // Write 1 to bit n to clear both counters of port n, reads as 0
    localparam apb_addr_t REG_COUNTER_CLEAR  = 8'h04;

    // Per-port counters are interleaved, stride 8
    localparam apb_addr_t REG_ING_COUNT_BASE = 8'h08;
    localparam apb_addr_t REG_EGR_COUNT_BASE = 8'h0C;
    localparam int        REG_COUNT_STRIDE   = 8;

endpackage

//--- verilog/router_regs.sv
/* APB register block: port enables, counter clear pulses and counter readback.
   Zero wait states, so every access is one setup and one access cycle. */
module router_regs (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [router_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [router_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [router_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic [router_pkg::NUM_PORTS-1:0]    port_enable,
    output logic [router_pkg::NUM_PORTS-1:0]    counter_clear,
    input  router_pkg::counter_t                ing_counts [router_pkg::NUM_PORTS],
    input  router_pkg::counter_t                egr_counts [router_pkg::NUM_PORTS]
);

    import router_pkg::*;

    logic                      access;
    logic                      wr_en;
    logic                      mapped;
    logic [APB_DATA_WIDTH-1:0] rd_data;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    assign pready = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Address decode and read mux

    always_comb begin
        mapped  = 1'b0;
        rd_data = '0;
        if (paddr == REG_PORT_ENABLE) begin
            mapped  = 1'b1;
            rd_data = APB_DATA_WIDTH'(port_enable);
        end else if (paddr == REG_COUNTER_CLEAR) begin
            mapped = 1'b1;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (paddr == apb_addr_t'(REG_ING_COUNT_BASE + REG_COUNT_STRIDE * p)) begin
                mapped  = 1'b1;
                rd_data = APB_DATA_WIDTH'(ing_counts[p]);
            end
            if (paddr == apb_addr_t'(REG_EGR_COUNT_BASE + REG_COUNT_STRIDE * p)) begin
                mapped  = 1'b1;
                rd_data = APB_DATA_WIDTH'(egr_counts[p]);
            end
        end
    end

    // Unmapped reads return 0 with an error
    assign prdata  = (access && mapped && !pwrite) ? rd_data : '0;
    assign pslverr = access && !mapped;

    //////////////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            port_enable   <= '0;
            counter_clear <= '0;
        end else begin
            if (wr_en && paddr == REG_PORT_ENABLE) begin
                port_enable <= pwdata[NUM_PORTS-1:0];
            end
            // Single-cycle pulse
            if (wr_en && paddr == REG_COUNTER_CLEAR) begin
                counter_clear <= pwdata[NUM_PORTS-1:0];
            end else begin
                counter_clear <= '0;
            end
        end
    end

    // Master must hold address and direction from setup into access
    a_apb_stable: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        access |-> $stable(paddr) && $stable(pwrite))
        else $error("router_regs paddr or pwrite changed between setup and access");

endmodule
